// ==== Bender.yml ====
package:
  name: williams_io

sources:
  - include_dirs:
      - src
    files:
      - src/williams_pkg.sv
      - src/core_config.sv
      - src/stick_quantizer.sv
      - src/input_mapper.sv
      - src/iir_stage.sv
      - src/sound_mixer.sv
      - src/williams_io_top.sv
  - target: test
    include_dirs:
      - src
    files:
      - bench/williams_io_sva.sv
      - bench/williams_io_tb.sv

// ==== bench/williams_io_sva.sv ====
`timescale 1ns/1ps

module williams_io_sva
	import williams_pkg::*;
(
	input logic        clk_sys,
	input logic        arst_n,
	input game_mode_e  game_mode,
	input logic [15:0] joy1,
	input logic [15:0] joy2,
	input logic [7:0]  game_audio,
	input logic [15:0] speech,
	input logic [7:0]  ja,
	input logic        landscape,
	input logic [15:0] audio_out
);

	int fail_count = 0;

	// Portrait cabinets drop the landscape flag one cycle after the mode
	a_landscape: assert property (@(posedge clk_sys) disable iff (!arst_n)
		landscape == !$past(game_mode == GAME_SINISTAR || game_mode == GAME_PLAYBALL))
	else
	begin
		fail_count++;
		$error("landscape flag does not follow the game mode");
	end

	// Bit 15 stays clear and outside Sinistar the mix is the raw sum over eight
	a_audio_mix: assert property (@(posedge clk_sys) disable iff (!arst_n)
		!audio_out[15] && (!$past(arst_n) || $past(game_mode == GAME_SINISTAR) ||
		audio_out == 16'(({1'b0, $past(game_audio), 8'h00} + {1'b0, $past(speech)}) >> 3)))
	else
	begin
		fail_count++;
		$error("audio_out bit 15 is set or the raw mix is wrong");
	end

	// Sinistar drives ja from the analog stick even with no pad pressed
	a_idle_ja: assert property (@(posedge clk_sys) disable iff (!arst_n)
		$past(game_mode != GAME_SINISTAR && joy1 == 16'h0000 && joy2 == 16'h0000)
		|-> ja == 8'hFF)
	else
	begin
		fail_count++;
		$error("ja is not all ones with no pad pressed");
	end

endmodule

bind williams_io_top williams_io_sva u_sva (
	.clk_sys    (clk_sys),
	.arst_n     (arst_n),
	.game_mode  (game_mode),
	.joy1       (joy1),
	.joy2       (joy2),
	.game_audio (game_audio),
	.speech     (speech),
	.ja         (ja),
	.landscape  (landscape),
	.audio_out  (audio_out)
);

// ==== bench/williams_io_tb.sv ====
`timescale 1ns/1ps
`include "williams_defines.svh"

module williams_io_tb
	import williams_pkg::*;
();

	localparam int CLK_PERIOD   = 100;
	localparam int RESET_CYCLES = 16;
	localparam int SETTLE_TICKS = 60;

	logic        clk_sys;
	logic        arst_n;
	logic        cfg_wr;
	logic [7:0]  cfg_index;
	logic [24:0] cfg_addr;
	logic [7:0]  cfg_data;
	logic [1:0]  opt_control;
	logic        sg_state;
	logic [15:0] joy1;
	logic [15:0] joy2;
	logic [15:0] joy1_analog;
	logic [15:0] joy2_analog;
	logic [7:0]  game_audio;
	logic [15:0] speech;
	logic [7:0]  ja;
	logic [7:0]  jb;
	logic [2:0]  btn;
	logic [7:0]  sw;
	logic        blitter_sc2;
	logic        sinistar;
	logic        landscape;
	logic [15:0] audio_out;

	int         errors = 0;
	int         checks = 0;
	bit         table_loaded = 1'b0;
	game_mode_e cur_mode = GAME_ROBOTRON;

	// Stimulus table held as one queue per column
	string       row_name [$];
	game_mode_e  row_mode [$];
	logic [1:0]  row_opt [$];
	logic        row_sg [$];
	logic [15:0] row_joy1 [$];
	logic [15:0] row_joy2 [$];
	logic [15:0] row_an1 [$];
	logic [15:0] row_an2 [$];
	logic [7:0]  row_ja [$];
	logic [7:0]  row_jb [$];
	logic [2:0]  row_btn [$];

	williams_io_top UUT (.*);

	initial
	begin
		clk_sys = 1'b0;
		forever #(CLK_PERIOD / 2) clk_sys = ~clk_sys;
	end

	function automatic logic [31:0] next_random(input logic [31:0] state);
		logic [31:0] x;
		x = state;
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	task automatic add_row(input string name, input game_mode_e mode, input logic [1:0] opt,
		input logic sg, input logic [15:0] j1, input logic [15:0] j2, input logic [15:0] a1,
		input logic [15:0] a2, input logic [7:0] eja, input logic [7:0] ejb,
		input logic [2:0] ebtn);
		row_name.push_back(name);
		row_mode.push_back(mode);
		row_opt.push_back(opt);
		row_sg.push_back(sg);
		row_joy1.push_back(j1);
		row_joy2.push_back(j2);
		row_an1.push_back(a1);
		row_an2.push_back(a2);
		row_ja.push_back(eja);
		row_jb.push_back(ejb);
		row_btn.push_back(ebtn);
	endtask

	////////////////////////////////////////
	// Expected port values are active low
	task automatic load_table();
		add_row("rob_idle", GAME_ROBOTRON, 0, 0, 'h0000, 'h0000, 0, 0, 'hFF, 'hFF, 'b000);
		add_row("rob_start1", GAME_ROBOTRON, 0, 0, 'h0400, 'h0000, 0, 0, 'hFF, 'hFF, 'b100);
		add_row("rob_coin", GAME_ROBOTRON, 0, 0, 'h0000, 'h1000, 0, 0, 'hFF, 'hFF, 'b001);
		add_row("rob_fire4", GAME_ROBOTRON, 0, 0, 'h0011, 'h0000, 0, 0, 'h77, 'h77, 'b000);
		add_row("rob_dual", GAME_ROBOTRON, 2, 0, 'h0008, 'h0002, 0, 0, 'hBE, 'hBE, 'b000);
		add_row("rob_single", GAME_ROBOTRON, 1, 0, 'h0004, 'h0000, 0, 0, 'hDD, 'hDD, 'b000);
		add_row("joust_p1", GAME_JOUST, 0, 0, 'h0011, 'h0000, 0, 0, 'hF9, 'hFF, 'b000);
		add_row("joust_p2", GAME_JOUST, 0, 0, 'h0000, 'h0002, 0, 0, 'hFF, 'hFE, 'b000);
		add_row("joust_start1", GAME_JOUST, 0, 0, 'h0400, 'h0000, 0, 0, 'hFF, 'hFF, 'b010);
		add_row("splat_fire", GAME_SPLAT, 0, 0, 'h0020, 'h0000, 0, 0, 'hDF, 'hFF, 'b000);
		add_row("splat_p2", GAME_SPLAT, 0, 0, 'h0000, 'h0088, 0, 0, 'hFF, 'hBE, 'b000);
		add_row("sg_rev_s0", GAME_STARGATE, 1, 0, 'h0001, 'h0000, 0, 0, 'hFD, 'hFD, 'b000);
		add_row("sg_thr_s0", GAME_STARGATE, 1, 0, 'h0002, 'h0000, 0, 0, 'hEF, 'hEF, 'b000);
		add_row("sg_rev_s1", GAME_STARGATE, 1, 1, 'h0002, 'h0000, 0, 0, 'hFD, 'hFD, 'b000);
		add_row("sg_thr_s1", GAME_STARGATE, 1, 1, 'h0001, 'h0000, 0, 0, 'hEF, 'hEF, 'b000);
		add_row("sg_opt0", GAME_STARGATE, 0, 0, 'h0028, 'h0000, 0, 0, 'hBD, 'hBD, 'b000);
		// Sinistar x in the low analog byte, y in the high byte
		add_row("sin_x_m100", GAME_SINISTAR, 0, 0, 0, 0, 'h009C, 0, 'hF8, 'hF8, 'b000);
		add_row("sin_x_m50", GAME_SINISTAR, 0, 0, 0, 0, 'h00CE, 0, 'h98, 'h98, 'b000);
		add_row("sin_centre", GAME_SINISTAR, 0, 0, 0, 0, 'h0000, 0, 'h88, 'h88, 'b000);
		add_row("sin_x_digital", GAME_SINISTAR, 0, 0, 'h0001, 0, 'h0000, 0, 'h78, 'h78, 'b000);
		add_row("sin_x_40", GAME_SINISTAR, 0, 0, 0, 0, 'h0028, 0, 'h48, 'h48, 'b000);
		add_row("sin_x_100", GAME_SINISTAR, 0, 0, 0, 0, 'h0064, 0, 'h78, 'h78, 'b000);
		add_row("sin_y_m100", GAME_SINISTAR, 0, 0, 0, 0, 'h9C00, 0, 'h87, 'h87, 'b000);
		add_row("sin_y_40", GAME_SINISTAR, 0, 0, 0, 0, 'h2800, 0, 'h89, 'h89, 'b000);
		add_row("sin_pad2", GAME_SINISTAR, 0, 0, 0, 'h0010, 'h0064, 'h00CE, 'h98, 'h98, 'b000);
		add_row("pb_starts", GAME_PLAYBALL, 0, 0, 'h1C00, 0, 0, 0, 'hF6, 'hF6, 'b001);
		add_row("bub_start2", GAME_BUBBLES, 0, 0, 'h0800, 0, 0, 0, 'hFF, 'hFF, 'b100);
		add_row("alien_p1", GAME_ALIENAR, 0, 0, 'h0011, 0, 0, 0, 'hE7, 'hFF, 'b000);
	endtask

	task automatic check_value(input string name, input logic [15:0] expected,
		input logic [15:0] actual);
		checks++;
		assert (actual === expected)
		else
		begin
			errors++;
			$display("MISMATCH %s: expected %h, actual %h", name, expected, actual);
		end
	endtask

	task automatic check_near(input string name, input int expected, input int actual,
		input int tol);
		checks++;
		assert ((actual >= expected - tol) && (actual <= expected + tol))
		else
		begin
			errors++;
			$display("MISMATCH %s: expected %h +/- %0d, actual %h", name, expected, tol, actual);
		end
	endtask

	task automatic write_cfg(input logic [7:0] index, input logic [24:0] addr,
		input logic [7:0] data);
		@(posedge clk_sys);
		cfg_wr    <= 1'b1;
		cfg_index <= index;
		cfg_addr  <= addr;
		cfg_data  <= data;
		@(posedge clk_sys);
		cfg_wr    <= 1'b0;
	endtask

	task automatic set_mode(input game_mode_e mode);
		if (mode != cur_mode)
		begin
			write_cfg(`CFG_IDX_MODE, 25'd0, mode);
			cur_mode = mode;
		end
	endtask

	task automatic apply_pads(input logic [15:0] pad1, input logic [15:0] pad2);
		@(posedge clk_sys);
		joy1 <= pad1;
		joy2 <= pad2;
		repeat (2) @(posedge clk_sys);
		@(negedge clk_sys);
	endtask

	// Two edges cover the player flag settling before the mapper register
	task automatic run_row(input int i);
		logic portrait;
		set_mode(row_mode[i]);
		@(posedge clk_sys);
		opt_control <= row_opt[i];
		sg_state    <= row_sg[i];
		joy1        <= row_joy1[i];
		joy2        <= row_joy2[i];
		joy1_analog <= row_an1[i];
		joy2_analog <= row_an2[i];
		repeat (2) @(posedge clk_sys);
		@(negedge clk_sys);
		portrait = (row_mode[i] == GAME_SINISTAR) || (row_mode[i] == GAME_PLAYBALL);
		check_value({row_name[i], " ja"}, row_ja[i], ja);
		check_value({row_name[i], " jb"}, row_jb[i], jb);
		check_value({row_name[i], " btn"}, row_btn[i], btn);
		check_value({row_name[i], " landscape"}, !portrait, landscape);
		check_value({row_name[i], " sinistar"}, row_mode[i] == GAME_SINISTAR, sinistar);
		// Only Splat has the SC2 blitter
		check_value({row_name[i], " blitter_sc2"}, row_mode[i] == GAME_SPLAT, blitter_sc2);
	endtask

	// Raw path is (game_audio * 256 + speech) / 8
	task automatic raw_mix_case(input string name, input logic [7:0] ga, input logic [15:0] sp);
		logic [16:0] sum;
		sum = {1'b0, ga, 8'h00} + {1'b0, sp};
		@(posedge clk_sys);
		game_audio <= ga;
		speech     <= sp;
		@(posedge clk_sys);
		@(negedge clk_sys);
		check_value(name, 16'(sum >> 3), audio_out);
	endtask

	initial
	begin
		logic [31:0] rnd;
		rnd         = 32'h13dd_93c5;
		arst_n      = 1'b0;
		cfg_wr      = 1'b0;
		cfg_index   = 8'h00;
		cfg_addr    = 25'd0;
		cfg_data    = 8'h00;
		opt_control = 2'b00;
		sg_state    = 1'b0;
		joy1        = 16'h0000;
		joy2        = 16'h0000;
		joy1_analog = 16'h0000;
		joy2_analog = 16'h0000;
		game_audio  = 8'h00;
		speech      = 16'h8000;
		load_table();
		table_loaded = 1'b1;
		repeat (RESET_CYCLES - 1) @(posedge clk_sys);
		// The mix register follows the idle inputs once out of reset
		@(negedge clk_sys);
		check_value("reset audio_out", 16'h0000, audio_out);
		@(posedge clk_sys);
		arst_n <= 1'b1;
		@(posedge clk_sys);
		@(negedge clk_sys);
		check_value("reset ja", 16'h00FF, ja);
		check_value("reset jb", 16'h00FF, jb);
		check_value("reset btn", 16'h0000, btn);
		check_value("reset landscape", 16'h0001, landscape);

		////////////////////////////////////////
		// DIP byte 0 with advance and auto-up on top
		write_cfg(`CFG_IDX_DIP, 25'd0, 8'hA4);
		apply_pads(16'h2000, 16'h0000);
		check_value("dip advance", 16'h00A6, sw);
		apply_pads(16'h0000, 16'h4000);
		check_value("dip autoup", 16'h00A5, sw);
		write_cfg(`CFG_IDX_DIP, 25'd1, 8'h0F);
		write_cfg(8'd2, 25'd0, 8'h06);
		apply_pads(16'h0000, 16'h0000);
		check_value("dip other addr", 16'h00A4, sw);
		check_value("bad index landscape", 16'h0001, landscape);
		check_value("bad index sinistar", 16'h0000, sinistar);

		foreach (row_name[i])
			run_row(i);

		////////////////////////////////////////
		// Audio
		set_mode(GAME_JOUST);
		raw_mix_case("raw_mix_max", 8'hFF, 16'hFFFF);
		for (int k = 0; k < 4; k++)
		begin
			rnd = next_random(rnd);
			raw_mix_case($sformatf("raw_mix_%0d", k), rnd[7:0], rnd[23:8]);
		end

		set_mode(GAME_SINISTAR);
		@(posedge clk_sys);
		game_audio <= 8'h10;
		speech     <= 16'h8400;
		repeat (SETTLE_TICKS * `SAMPLE_DIV) @(posedge clk_sys);
		@(negedge clk_sys);
		// Unity DC gain then times four puts 0x400 above midscale at 0x1000
		check_near("sinistar_lpf_dc", (17'h01000 + 17'h09000) >> 3, audio_out, 4);

		@(posedge clk_sys);
		speech <= 16'hE000;
		repeat (SETTLE_TICKS * `SAMPLE_DIV) @(posedge clk_sys);
		@(negedge clk_sys);
		check_value("sinistar_saturate", 16'((17'h01000 + 17'h0FFFF) >> 3), audio_out);

		$display("Checks run: %0d, failed checks: %0d, assertion failures: %0d",
			checks, errors, UUT.u_sva.fail_count);
		if (errors == 0 && UUT.u_sva.fail_count == 0)
			$display("No errors");
		else
			$display("Errors found");
		$finish;
	end

	// Watchdog sized from the table length and the two filter settling waits
	initial
	begin
		wait (table_loaded);
		repeat (row_name.size() * 10 + 4 * SETTLE_TICKS * `SAMPLE_DIV) @(posedge clk_sys);
		$display("Watchdog expired, the test sequence did not finish in time");
		$display("Errors found");
		$finish;
	end

endmodule

// ==== compile.f ====
+incdir+src
src/williams_pkg.sv
src/core_config.sv
src/stick_quantizer.sv
src/input_mapper.sv
src/iir_stage.sv
src/sound_mixer.sv
src/williams_io_top.sv
bench/williams_io_sva.sv
bench/williams_io_tb.sv

// ==== src/core_config.sv ====
`timescale 1ns/1ps
`include "williams_defines.svh"

module core_config
	import williams_pkg::*;
(
	input  logic        clk_sys,
	input  logic        arst_n,
	input  logic        cfg_wr,
	input  logic [7:0]  cfg_index,
	input  logic [24:0] cfg_addr,
	input  logic [7:0]  cfg_data,
	output game_mode_e  game_mode,
	output logic [7:0]  dip0
);

	logic dip0_hit;

	// Only DIP byte 0 is kept, so the whole address must be zero
	assign dip0_hit = (cfg_index == `CFG_IDX_DIP) && (cfg_addr == 25'd0);

	always_ff @(posedge clk_sys or negedge arst_n)
	begin
		if (!arst_n)
		begin
			game_mode <= GAME_ROBOTRON;
			dip0      <= 8'h00;
		end
		else if (cfg_wr)
		begin
			if (cfg_index == `CFG_IDX_MODE)
				game_mode <= game_mode_e'(cfg_data);
			else if (dip0_hit)
				dip0 <= cfg_data;
		end
	end

endmodule

// ==== src/iir_stage.sv ====
`timescale 1ns/1ps
`include "williams_defines.svh"

module iir_stage
	import williams_pkg::*;
(
	input  logic    clk_sys,
	input  logic    arst_n,
	input  sample_t in,
	output sample_t out
);

	localparam int DIV_W = $clog2(`SAMPLE_DIV);
	localparam int ACC_W = `IIR_COEFF_W + 18;

	localparam logic signed [`IIR_COEFF_W-1:0] A2 = `IIR_A2;
	localparam logic signed [`IIR_COEFF_W-1:0] B1 = `IIR_B1;
	localparam logic signed [`IIR_COEFF_W-1:0] B2 = `IIR_B2;

	logic [DIV_W-1:0]        div_cnt;
	logic                    tick;
	sample_t                 x_prev;
	logic signed [ACC_W-1:0] acc;

	assign tick = (div_cnt == DIV_W'(`SAMPLE_DIV - 1));

	// y[n] = B1 x[n] + B2 x[n-1] - A2 y[n-1], coefficients sum to unity gain
	assign acc = B1 * in + B2 * x_prev - A2 * out;

	always_ff @(posedge clk_sys or negedge arst_n)
	begin
		if (!arst_n)
		begin
			div_cnt <= '0;
			x_prev  <= '0;
			out     <= '0;
		end
		else
		begin
			div_cnt <= tick ? '0 : div_cnt + 1'b1;
			if (tick)
			begin
				x_prev <= in;
				out    <= sample_t'(acc >>> `IIR_SCALE);
			end
		end
	end

endmodule

// ==== src/input_mapper.sv ====
`timescale 1ns/1ps
`include "williams_defines.svh"

module input_mapper
	import williams_pkg::*;
(
	input  logic        clk_sys,
	input  logic        arst_n,
	input  game_mode_e  game_mode,
	input  logic [7:0]  dip0,
	input  logic [1:0]  opt_control,
	input  logic        sg_state,
	input  logic [15:0] joy1,
	input  logic [15:0] joy2,
	input  stick_code_t stick_x,
	input  stick_code_t stick_y,
	output logic [7:0]  ja,
	output logic [7:0]  jb,
	output logic [2:0]  btn,
	output logic [7:0]  sw,
	output logic        blitter_sc2,
	output logic        sinistar,
	output logic        landscape
);

	logic [15:0] joy;
	logic [7:0]  ja_d, jb_d, sw_d;
	logic [2:0]  btn_d;
	logic        blitter_d, sinistar_d, landscape_d;
	logic        sg_thrust, sg_reverse;

	// Board order is right, left, down, up
	function automatic logic [3:0] dirs(input logic [15:0] pad);
		return {pad[`PAD_RIGHT], pad[`PAD_LEFT], pad[`PAD_DOWN], pad[`PAD_UP]};
	endfunction

	// Fire buttons used as a second 4-way stick
	function automatic logic [3:0] fire4(input logic [15:0] pad);
		return {pad[`PAD_FIRE_A], pad[`PAD_FIRE_D], pad[`PAD_FIRE_B], pad[`PAD_FIRE_C]};
	endfunction

	assign joy = joy1 | joy2;

	// Stargate thrust and reverse follow the ship facing in sg_state
	assign sg_thrust  = (opt_control == 2'b10) ? joy[`PAD_FIRE_E] :
	                    opt_control[0] ? (sg_state ? joy[`PAD_RIGHT] : joy[`PAD_LEFT]) :
	                    (joy[`PAD_LEFT] | joy[`PAD_RIGHT]);
	assign sg_reverse = opt_control[0] ? (sg_state ? joy[`PAD_LEFT] : joy[`PAD_RIGHT]) :
	                    joy[`PAD_FIRE_B];

	assign sw_d = dip0 | {6'b000000, joy[`PAD_ADVANCE], joy[`PAD_AUTOUP]};

	////////////////////////////////////////
	// Per-game mapping, ports are active low
	always_comb
	begin
		ja_d        = 8'hFF;
		jb_d        = 8'hFF;
		btn_d       = 3'b000;
		blitter_d   = 1'b0;
		sinistar_d  = 1'b0;
		landscape_d = 1'b1;
		case (game_mode)
			GAME_ROBOTRON:
			begin
				btn_d = {joy[`PAD_START1], joy[`PAD_START2], joy[`PAD_COIN]};
				ja_d  = ~{opt_control[1] ? dirs(joy2) : (opt_control[0] ? dirs(joy) : fire4(joy)),
				          opt_control[1] ? dirs(joy1) : dirs(joy)};
				jb_d  = ja_d;
			end
			GAME_JOUST:
			begin
				btn_d = {joy[`PAD_START2], joy[`PAD_START1], joy[`PAD_COIN]};
				ja_d  = ~{5'b00000, joy1[`PAD_FIRE_A], joy1[`PAD_RIGHT], joy1[`PAD_LEFT]};
				jb_d  = ~{5'b00000, joy2[`PAD_FIRE_A], joy2[`PAD_RIGHT], joy2[`PAD_LEFT]};
			end
			GAME_SPLAT:
			begin
				blitter_d = 1'b1;
				btn_d = {joy[`PAD_START1], joy[`PAD_START2], joy[`PAD_COIN]};
				ja_d  = ~{opt_control[0] ? dirs(joy1) : fire4(joy1), dirs(joy1)};
				jb_d  = ~{opt_control[0] ? dirs(joy2) : fire4(joy2), dirs(joy2)};
			end
			GAME_BUBBLES:
			begin
				btn_d = {joy[`PAD_START2], joy[`PAD_START1], joy[`PAD_COIN]};
				ja_d  = ~{4'b0000, dirs(joy)};
				jb_d  = ja_d;
			end
			GAME_STARGATE:
			begin
				btn_d = {joy[`PAD_START2], joy[`PAD_START1], joy[`PAD_COIN]};
				ja_d  = ~{joy[`PAD_FIRE_F], joy[`PAD_UP], joy[`PAD_DOWN], sg_thrust,
				          joy[`PAD_FIRE_D], joy[`PAD_FIRE_C], sg_reverse, joy[`PAD_FIRE_A]};
				jb_d  = ja_d;
			end
			GAME_ALIENAR:
			begin
				btn_d = {joy[`PAD_START1], joy[`PAD_START2], joy[`PAD_COIN]};
				ja_d  = ~{2'b00, joy1[`PAD_FIRE_B], joy1[`PAD_FIRE_A], dirs(joy1)};
				jb_d  = ~{2'b00, joy2[`PAD_FIRE_B], joy2[`PAD_FIRE_A], dirs(joy2)};
			end
			GAME_SINISTAR:
			begin
				sinistar_d  = 1'b1;
				landscape_d = 1'b0;
				btn_d = {joy[`PAD_START1], joy[`PAD_START2], joy[`PAD_COIN]};
				ja_d  = ~{stick_x, stick_y};
				jb_d  = ja_d;
			end
			GAME_PLAYBALL:
			begin
				landscape_d = 1'b0;
				// Starts live on the joystick port here
				btn_d = {2'b00, joy[`PAD_COIN]};
				ja_d  = ~{4'b0000, joy[`PAD_START2], joy[`PAD_RIGHT], joy[`PAD_LEFT],
				          joy[`PAD_START1]};
				jb_d  = ja_d;
			end
			default: ;
		endcase
	end

	always_ff @(posedge clk_sys or negedge arst_n)
	begin
		if (!arst_n)
		begin
			ja          <= 8'hFF;
			jb          <= 8'hFF;
			btn         <= 3'b000;
			sw          <= 8'h00;
			blitter_sc2 <= 1'b0;
			sinistar    <= 1'b0;
			landscape   <= 1'b1;
		end
		else
		begin
			ja          <= ja_d;
			jb          <= jb_d;
			btn         <= btn_d;
			sw          <= sw_d;
			blitter_sc2 <= blitter_d;
			sinistar    <= sinistar_d;
			landscape   <= landscape_d;
		end
	end

endmodule

// ==== src/sound_mixer.sv ====
`timescale 1ns/1ps

module sound_mixer
	import williams_pkg::*;
(
	input  logic        clk_sys,
	input  logic        arst_n,
	input  game_mode_e  game_mode,
	input  logic [7:0]  game_audio,
	input  logic [15:0] speech,
	output logic [15:0] audio_out
);

	sample_t            stage [0:4];
	logic signed [17:0] boosted;
	sample_t            s_final;
	logic [15:0]        speech_sel;
	logic [16:0]        audsum;

	// Offset binary to two's complement
	assign stage[0] = sample_t'(speech - 16'h8000);

	////////////////////////////////////////
	// Low-pass cascade modelling the speech op-amp filter
	for (genvar i = 0; i < 4; i++)
	begin : g_lpf
		iir_stage u_stage (
			.clk_sys (clk_sys),
			.arst_n  (arst_n),
			.in      (stage[i]),
			.out     (stage[i+1])
		);
	end

	// Gain of 4, clipped to the 16-bit range
	assign boosted = {stage[4][15], stage[4][15], stage[4]} <<< 2;
	assign s_final = (boosted > 18'sd32767)  ? 16'sh7FFF :
	                 (boosted < -18'sd32768) ? 16'sh8000 : boosted[15:0];

	assign speech_sel = (game_mode == GAME_SINISTAR) ? (s_final + 16'h8000) : speech;
	assign audsum     = {1'b0, game_audio, 8'h00} + {1'b0, speech_sel};

	always_ff @(posedge clk_sys or negedge arst_n)
	begin
		if (!arst_n)
			audio_out <= 16'h0000;
		else
			audio_out <= {1'b0, audsum[16:2]} >> 1;
	end

endmodule

// ==== src/stick_quantizer.sv ====
`timescale 1ns/1ps
`include "williams_defines.svh"

module stick_quantizer
	import williams_pkg::*;
(
	input  logic        clk_sys,
	input  logic        arst_n,
	input  logic [15:0] joy1,
	input  logic [15:0] joy2,
	input  logic [15:0] joy1_analog,
	input  logic [15:0] joy2_analog,
	output stick_code_t stick_x,
	output stick_code_t stick_y
);

	logic        use_p2;
	logic [15:0] joya;
	stick_code_t amx, amy, dmx, dmy;

	// X-axis style code from a signed byte
	function automatic stick_code_t quantize(input logic signed [7:0] v);
		if (v < -(`STICK_T3))
			return 4'd0;
		else if (v < -(`STICK_T2))
			return 4'd4;
		else if (v < -(`STICK_T1))
			return 4'd6;
		else if (v > `STICK_T3)
			return 4'd8;
		else if (v > `STICK_T2)
			return 4'd9;
		else if (v > `STICK_T1)
			return 4'd11;
		return STICK_CENTRE;
	endfunction

	// Y runs the other way, swap the two code sets
	function automatic stick_code_t mirror(input stick_code_t c);
		case (c)
			4'd0:    return 4'd8;
			4'd4:    return 4'd9;
			4'd6:    return 4'd11;
			4'd8:    return 4'd0;
			4'd9:    return 4'd4;
			4'd11:   return 4'd6;
			default: return c;
		endcase
	endfunction

	// Last player to touch a pad owns the analog stick, player 1 wins a tie
	always_ff @(posedge clk_sys or negedge arst_n)
	begin
		if (!arst_n)
			use_p2 <= 1'b0;
		else if (|joy1)
			use_p2 <= 1'b0;
		else if (|joy2)
			use_p2 <= 1'b1;
	end

	assign joya = use_p2 ? joy2_analog : joy1_analog;
	assign amx  = quantize(joya[7:0]);
	assign amy  = mirror(quantize(joya[15:8]));

	// Digital fallback uses both pads together
	assign dmx = (joy1[`PAD_LEFT] | joy2[`PAD_LEFT]) ? 4'd0 :
	             (joy1[`PAD_RIGHT] | joy2[`PAD_RIGHT]) ? 4'd8 : STICK_CENTRE;
	assign dmy = (joy1[`PAD_DOWN] | joy2[`PAD_DOWN]) ? 4'd0 :
	             (joy1[`PAD_UP] | joy2[`PAD_UP]) ? 4'd8 : STICK_CENTRE;

	assign stick_x = (amx == STICK_CENTRE) ? dmx : amx;
	assign stick_y = (amy == STICK_CENTRE) ? dmy : amy;

endmodule

// ==== src/williams_defines.svh ====
`ifndef WILLIAMS_DEFINES_SVH
`define WILLIAMS_DEFINES_SVH

// Download index values
`define CFG_IDX_MODE 8'd1
`define CFG_IDX_DIP  8'd254

// Pad word bit positions, same layout for both players
`define PAD_RIGHT    0
`define PAD_LEFT     1
`define PAD_DOWN     2
`define PAD_UP       3
`define PAD_FIRE_A   4
`define PAD_FIRE_B   5
`define PAD_FIRE_C   6
`define PAD_FIRE_D   7
`define PAD_FIRE_E   8
`define PAD_FIRE_F   9
`define PAD_START1   10
`define PAD_START2   11
`define PAD_COIN     12
`define PAD_ADVANCE  13
`define PAD_AUTOUP   14

// Analog stick thresholds on the signed byte
`define STICK_T1     32
`define STICK_T2     64
`define STICK_T3     96

// Speech low-pass, Q15 coefficients, about 3.4 kHz over four stages
`define IIR_A2       -20502
`define IIR_B1       6133
`define IIR_B2       6133
`define IIR_SCALE    15
`define IIR_COEFF_W  22
`define SAMPLE_DIV   256

`endif

// ==== src/williams_io_top.sv ====
`timescale 1ns/1ps

module williams_io_top
	import williams_pkg::*;
(
	input  logic        clk_sys,
	input  logic        arst_n,
	input  logic        cfg_wr,
	input  logic [7:0]  cfg_index,
	input  logic [24:0] cfg_addr,
	input  logic [7:0]  cfg_data,
	input  logic [1:0]  opt_control,
	input  logic        sg_state,
	input  logic [15:0] joy1,
	input  logic [15:0] joy2,
	input  logic [15:0] joy1_analog,
	input  logic [15:0] joy2_analog,
	input  logic [7:0]  game_audio,
	input  logic [15:0] speech,
	output logic [7:0]  ja,
	output logic [7:0]  jb,
	output logic [2:0]  btn,
	output logic [7:0]  sw,
	output logic        blitter_sc2,
	output logic        sinistar,
	output logic        landscape,
	output logic [15:0] audio_out
);

	game_mode_e  game_mode;
	logic [7:0]  dip0;
	stick_code_t stick_x, stick_y;

	core_config u_config (
		.clk_sys   (clk_sys),
		.arst_n    (arst_n),
		.cfg_wr    (cfg_wr),
		.cfg_index (cfg_index),
		.cfg_addr  (cfg_addr),
		.cfg_data  (cfg_data),
		.game_mode (game_mode),
		.dip0      (dip0)
	);

	stick_quantizer u_stick (
		.clk_sys     (clk_sys),
		.arst_n      (arst_n),
		.joy1        (joy1),
		.joy2        (joy2),
		.joy1_analog (joy1_analog),
		.joy2_analog (joy2_analog),
		.stick_x     (stick_x),
		.stick_y     (stick_y)
	);

	input_mapper u_mapper (
		.clk_sys     (clk_sys),
		.arst_n      (arst_n),
		.game_mode   (game_mode),
		.dip0        (dip0),
		.opt_control (opt_control),
		.sg_state    (sg_state),
		.joy1        (joy1),
		.joy2        (joy2),
		.stick_x     (stick_x),
		.stick_y     (stick_y),
		.ja          (ja),
		.jb          (jb),
		.btn         (btn),
		.sw          (sw),
		.blitter_sc2 (blitter_sc2),
		.sinistar    (sinistar),
		.landscape   (landscape)
	);

	sound_mixer u_mixer (
		.clk_sys    (clk_sys),
		.arst_n     (arst_n),
		.game_mode  (game_mode),
		.game_audio (game_audio),
		.speech     (speech),
		.audio_out  (audio_out)
	);

endmodule

// ==== src/williams_pkg.sv ====
package williams_pkg;

	////////////////////////////////////////
	// Game select, loaded from download index 1
	typedef enum logic [7:0]
	{
		GAME_ROBOTRON = 8'd0,
		GAME_JOUST    = 8'd1,
		GAME_SPLAT    = 8'd2,
		GAME_BUBBLES  = 8'd3,
		GAME_STARGATE = 8'd4,
		GAME_ALIENAR  = 8'd5,
		GAME_SINISTAR = 8'd6,
		GAME_PLAYBALL = 8'd7
	} game_mode_e;

	// Signed speech sample inside the filter path
	typedef logic signed [15:0] sample_t;

	// Sinistar 49-way stick position code
	typedef logic [3:0] stick_code_t;

	localparam stick_code_t STICK_CENTRE = 4'd7;

endpackage
